/* include/viterbi_config.svh */
// viterbi decoder sizing: block depth, trellis states and metric widths
`ifndef VITERBI_CONFIG_SVH
`define VITERBI_CONFIG_SVH

// symbols per decoded block
`define VIT_TB_DEPTH 16

`define VIT_NUM_STATES 4
`define VIT_METRIC_W 8

// above the 2 x 16 worst case a block can add up
`define VIT_INIT_METRIC 64

`endif

/* src/viterbi_code_pkg.sv */
// trellis types and encoder rules for the rate 1/2, K = 3 code with generators 7 and 5
`default_nettype none
`include "viterbi_config.svh"

package viterbi_code_pkg;

    // bit 1 newest input, bit 0 the one before
    typedef logic [$clog2(`VIT_NUM_STATES)-1:0] state_t;

    // bit 1 from g = 7, bit 0 from g = 5
    typedef logic [1:0] sym_t;

    // symbol the encoder emits from state s on input bit u
    function automatic sym_t expected_sym(state_t s, logic u);
        sym_t y;
        y[1] = u ^ s[1] ^ s[0]; // 111
        y[0] = u ^ s[0];        // 101
        return y;
    endfunction

    // predecessor of s selected by decision bit x
    function automatic state_t pred_state(state_t s, logic x);
        state_t p;
        p = {s[0], x};
        return p;
    endfunction

endpackage

`default_nettype wire

/* src/viterbi_path_pkg.sv */
// path-side types: metrics, decision vectors and survivor addresses
`default_nettype none
`include "viterbi_config.svh"

package viterbi_path_pkg;

    typedef logic [`VIT_METRIC_W-1:0] metric_t;

    // one survivor bit per trellis state
    typedef logic [`VIT_NUM_STATES-1:0] decision_t;

    // step index within a block
    typedef logic [$clog2(`VIT_TB_DEPTH)-1:0] addr_t;

endpackage

`default_nettype wire

/* src/acs_unit.sv */
// add-compare-select over the 4-state trellis with block step count and best end state
`timescale 1ns/10ps
`default_nettype none
`include "viterbi_config.svh"

module acs_unit
    import viterbi_code_pkg::*;
    import viterbi_path_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        i_valid,
    input  wire sym_t  i_sym,
    output logic       o_dec_we,
    output addr_t      o_dec_addr,
    output decision_t  o_dec,
    output logic       o_blk_end,
    output state_t     o_best_state,
    output metric_t    o_best_metric
);
    localparam int N = `VIT_NUM_STATES;

    metric_t   pm [N];
    metric_t   pm_next [N];
    decision_t dec;
    addr_t     step;
    logic      last_step;
    state_t    best_s;
    metric_t   best_m;

    // hamming distance of two hard symbols
    function automatic metric_t hamming(sym_t a, sym_t b);
        sym_t d;
        d = a ^ b;
        return metric_t'(d[1]) + metric_t'(d[0]);
    endfunction

    // every block starts in state 0
    function automatic metric_t init_metric(int s);
        return (s == 0) ? '0 : metric_t'(`VIT_INIT_METRIC);
    endfunction

    assign last_step = (step == addr_t'(`VIT_TB_DEPTH - 1));

    always_comb
    begin
        state_t  s;
        state_t  p0;
        state_t  p1;
        metric_t m0;
        metric_t m1;
        for (int i = 0; i < N; i++)
        begin
            s  = state_t'(i);
            p0 = pred_state(s, 1'b0);
            p1 = pred_state(s, 1'b1);
            // input bit on both branches into s is s[1]
            m0 = pm[p0] + hamming(i_sym, expected_sym(p0, s[1]));
            m1 = pm[p1] + hamming(i_sym, expected_sym(p1, s[1]));
            dec[i]     = (m1 < m0);         // tie keeps x = 0
            pm_next[i] = (m1 < m0) ? m1 : m0;
        end
    end

    // lowest-numbered state wins among equal minima
    always_comb
    begin
        best_s = '0;
        best_m = pm_next[0];
        for (int i = 1; i < N; i++)
        begin
            if (pm_next[i] < best_m)
            begin
                best_s = state_t'(i);
                best_m = pm_next[i];
            end
        end
    end

    assign o_dec_we   = i_valid;
    assign o_dec_addr = step;
    assign o_dec      = dec;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            step      <= '0;
            o_blk_end <= 1'b0;
            for (int i = 0; i < N; i++)
                pm[i] <= init_metric(i);
        end
        else
        begin
            o_blk_end <= i_valid && last_step;
            if (i_valid)
            begin
                step <= step + 1'b1; // wraps to 0 after the last step
                for (int i = 0; i < N; i++)
                    pm[i] <= last_step ? init_metric(i) : pm_next[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_valid && last_step)
        begin
            o_best_state  <= best_s;
            o_best_metric <= best_m;
        end
    end

    // a block of hard symbols costs at most 2 per step
    assert property (@(posedge clk) disable iff (!rst)
        o_blk_end |-> (o_best_metric <= metric_t'(2 * `VIT_TB_DEPTH)))
        else $error("acs_unit: best metric %0d above block bound", o_best_metric);

endmodule

`default_nettype wire

/* src/survivor_mem.sv */
// double-banked survivor memory, one bank written while the other is read back
`timescale 1ns/10ps
`default_nettype none
`include "viterbi_config.svh"

module survivor_mem
    import viterbi_path_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             i_we,
    input  wire addr_t      i_wr_addr,
    input  wire decision_t  i_wr_data,
    input  wire addr_t      i_rd_addr,
    output decision_t       o_rd_data
);
    decision_t mem [2][`VIT_TB_DEPTH];
    logic      wr_bank;
    addr_t     exp_addr;

    always_ff @(posedge clk)
    begin
        if (i_we)
            mem[wr_bank][i_wr_addr] <= i_wr_data;
        o_rd_data <= mem[~wr_bank][i_rd_addr]; // read side is the finished bank
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_bank  <= 1'b0;
            exp_addr <= '0;
        end
        else if (i_we)
        begin
            exp_addr <= exp_addr + 1'b1;
            // swap banks once the last step of a block is stored
            if (i_wr_addr == addr_t'(`VIT_TB_DEPTH - 1))
                wr_bank <= ~wr_bank;
        end
    end

    // decisions arrive one step after another, restarting at 0 each block
    assert property (@(posedge clk) disable iff (!rst)
        i_we |-> (i_wr_addr == exp_addr))
        else $error("survivor_mem: write to %0d, expected %0d", i_wr_addr, exp_addr);

endmodule

`default_nettype wire

/* src/traceback_unit.sv */
// traceback from the best end state through stored decisions, assembling one decoded block
`timescale 1ns/10ps
`default_nettype none
`include "viterbi_config.svh"

module traceback_unit
    import viterbi_code_pkg::*;
    import viterbi_path_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             i_blk_end,
    input  wire state_t     i_best_state,
    input  wire metric_t    i_best_metric,
    input  wire decision_t  i_rd_data,
    output addr_t           o_rd_addr,
    output logic [`VIT_TB_DEPTH-1:0] o_block,
    output logic            o_block_valid,
    output metric_t         o_block_metric
);
    addr_t   rd_addr;       // rests at the last step when idle
    logic    issuing;
    logic    cons_valid;    // i_rd_data holds step cons_addr
    addr_t   cons_addr;
    state_t  cur_state;
    logic    dec_bit;
    metric_t blk_metric;
    logic [`VIT_TB_DEPTH-2:0] shift_q;
    logic [`VIT_TB_DEPTH-1:0] shift_next;

    assign issuing    = i_blk_end || (rd_addr != addr_t'(`VIT_TB_DEPTH - 1));
    assign o_rd_addr  = rd_addr;
    assign dec_bit    = cur_state[1]; // newest input bit of the state
    assign shift_next = {shift_q, dec_bit};

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rd_addr       <= addr_t'(`VIT_TB_DEPTH - 1);
            cons_valid    <= 1'b0;
            cons_addr     <= '0;
            o_block_valid <= 1'b0;
        end
        else
        begin
            if (issuing)
                rd_addr <= rd_addr - 1'b1;  // step 0 wraps back to idle
            cons_valid    <= issuing;
            cons_addr     <= rd_addr;
            o_block_valid <= cons_valid && (cons_addr == '0);
        end
    end

    always_ff @(posedge clk)
    begin
        // a new block may start on the cycle the previous one finishes
        if (i_blk_end)
        begin
            cur_state  <= i_best_state;
            blk_metric <= i_best_metric;
        end
        else if (cons_valid)
        begin
            cur_state <= pred_state(cur_state, i_rd_data[cur_state]);
        end

        // steps come out last first, so after 16 shifts bit k is step k
        if (cons_valid)
            shift_q <= shift_next[`VIT_TB_DEPTH-2:0];

        if (cons_valid && (cons_addr == '0))
        begin
            o_block        <= shift_next;
            o_block_metric <= blk_metric;
        end
    end

    // blocks are at least 16 symbols apart, so reads never overlap
    assert property (@(posedge clk) disable iff (!rst)
        i_blk_end |-> (rd_addr == addr_t'(`VIT_TB_DEPTH - 1)))
        else $error("traceback_unit: block end at read address %0d", rd_addr);

endmodule

`default_nettype wire

/* src/viterbi_top.sv */
// hard-decision viterbi decoder top: acs, survivor memory and traceback
`timescale 1ns/10ps
`default_nettype none
`include "viterbi_config.svh"

module viterbi_top
    import viterbi_code_pkg::*;
    import viterbi_path_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        i_valid,
    input  wire sym_t  i_sym,
    output logic [`VIT_TB_DEPTH-1:0] o_block,
    output logic       o_block_valid,
    output metric_t    o_block_metric
);
    logic      dec_we;
    addr_t     dec_addr;
    decision_t dec;
    logic      blk_end;
    state_t    best_state;
    metric_t   best_metric;
    addr_t     rd_addr;
    decision_t rd_data;

    acs_unit acs_unit_i (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (i_valid),
        .i_sym         (i_sym),
        .o_dec_we      (dec_we),
        .o_dec_addr    (dec_addr),
        .o_dec         (dec),
        .o_blk_end     (blk_end),
        .o_best_state  (best_state),
        .o_best_metric (best_metric)
    );

    survivor_mem survivor_mem_i (
        .clk       (clk),
        .rst       (rst),
        .i_we      (dec_we),
        .i_wr_addr (dec_addr),
        .i_wr_data (dec),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    traceback_unit traceback_unit_i (
        .clk            (clk),
        .rst            (rst),
        .i_blk_end      (blk_end),
        .i_best_state   (best_state),
        .i_best_metric  (best_metric),
        .i_rd_data      (rd_data),
        .o_rd_addr      (rd_addr),
        .o_block        (o_block),
        .o_block_valid  (o_block_valid),
        .o_block_metric (o_block_metric)
    );

endmodule

`default_nettype wire

/* testbench/tb_viterbi.sv */
// viterbi decoder testbench comparing noisy random blocks with a software decoder
`timescale 1ns/10ps
`default_nettype none
`include "viterbi_config.svh"

module tb_viterbi
    import viterbi_code_pkg::*;
    import viterbi_path_pkg::*;
();
    localparam int DEPTH      = `VIT_TB_DEPTH;
    localparam int CLK_HALF   = 2;
    localparam int MAX_GAP    = 3;
    localparam int NUM_BLOCKS = 24;
    localparam int LATENCY    = 18; // blk_end one cycle after the last symbol and valid 17 later
    localparam int EXP_CYCLES = 20 + NUM_BLOCKS * DEPTH * (1 + MAX_GAP) + 2 * DEPTH;
    localparam int NOISE_NONE  = 0;
    localparam int NOISE_ONE   = 1;
    localparam int NOISE_DENSE = 2;

    logic             clk;
    logic             rst;
    logic             i_valid;
    sym_t             i_sym;
    logic [DEPTH-1:0] o_block;
    logic             o_block_valid;
    metric_t          o_block_metric;
    logic [15:0]      lfsr;
    int               cyc;
    int               blocks_done;
    logic [DEPTH-1:0] exp_block_q [$];
    int               exp_metric_q [$];
    int               exp_cycle_q [$];

    viterbi_top viterbi_top_i (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .i_sym          (i_sym),
        .o_block        (o_block),
        .o_block_valid  (o_block_valid),
        .o_block_metric (o_block_metric)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial
    begin
        #(2 * EXP_CYCLES * 2 * CLK_HALF);
        $display("watchdog: decoder did not finish within %0d cycles", 2 * EXP_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    // 16-bit galois lfsr stepped once per random bit
    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // taps {u, d1, d2} give the g = 7 bit then the g = 5 bit
    function automatic sym_t encode_bit(logic [2:0] taps);
        sym_t y;
        y[1] = ^(taps & 3'b111);
        y[0] = ^(taps & 3'b101);
        return y;
    endfunction

    task automatic report_mismatch(string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    // reference decoder for one block of received symbols
    task automatic model_decode(input logic [2*DEPTH-1:0] rx, output logic [DEPTH-1:0] bits,
                                output int metric);
        int         pm [4];
        int         nm [4];
        logic [3:0] dec [DEPTH];
        logic [1:0] s;
        logic [1:0] p0;
        logic [1:0] p1;
        int         m0;
        int         m1;
        pm = '{0, `VIT_INIT_METRIC, `VIT_INIT_METRIC, `VIT_INIT_METRIC};
        for (int k = 0; k < DEPTH; k++)
        begin
            for (int ns = 0; ns < 4; ns++)
            begin
                s  = 2'(ns);
                p0 = {s[0], 1'b0};
                p1 = {s[0], 1'b1};
                m0 = pm[p0] + $countones(rx[2*k +: 2] ^ encode_bit({s[1], p0}));
                m1 = pm[p1] + $countones(rx[2*k +: 2] ^ encode_bit({s[1], p1}));
                dec[k][ns] = (m1 < m0);
                nm[ns] = (m1 < m0) ? m1 : m0;
            end
            pm = nm;
        end
        s = 2'd0;
        for (int i = 1; i < 4; i++)
            if (pm[i] < pm[s])
                s = 2'(i);
        metric = pm[s];
        for (int k = DEPTH - 1; k >= 0; k--)
        begin
            bits[k] = s[1];
            s = {s[0], dec[k][s]};
        end
    endtask

    task automatic check_outputs();
        assert (!$isunknown(o_block_valid)) else report_failure("o_block_valid is unknown");
        if (exp_cycle_q.size() > 0)
            assert (cyc <= exp_cycle_q[0])
                else report_failure("decoded block did not appear when due");
        if (o_block_valid)
        begin
            assert (exp_cycle_q.size() > 0)
                else report_failure("o_block_valid with no block pending");
            assert (cyc == exp_cycle_q[0]) else report_mismatch($sformatf(
                "block %0d valid at cycle %0d, expected %0d", blocks_done, cyc, exp_cycle_q[0]));
            assert (o_block == exp_block_q[0]) else report_mismatch($sformatf(
                "block %0d is %h, expected %h", blocks_done, o_block, exp_block_q[0]));
            assert (o_block_metric == metric_t'(exp_metric_q[0])) else report_mismatch($sformatf(
                "block %0d metric %0d, expected %0d", blocks_done, o_block_metric,
                exp_metric_q[0]));
            void'(exp_cycle_q.pop_front());
            void'(exp_block_q.pop_front());
            void'(exp_metric_q.pop_front());
            blocks_done++;
        end
    endtask

    // outputs are checked at the falling edge before new inputs go out
    task automatic tick();
        @(negedge clk);
        cyc++;
        check_outputs();
    endtask

    task automatic run_block(input int noise, input logic gaps);
        logic [DEPTH-1:0]   data;
        logic [DEPTH-1:0]   exp_bits;
        logic [2*DEPTH-1:0] rx;
        logic [1:0]         st;
        int                 exp_metric;
        st = 2'd0; // encoder restarts each block
        for (int k = 0; k < DEPTH; k++)
        begin
            data[k] = 1'(rand_bits(1));
            rx[2*k +: 2] = encode_bit({data[k], st});
            st = {data[k], st[1]};
            if (noise == NOISE_DENSE)
                for (int b = 0; b < 2; b++)
                    if (rand_bits(2) == 0)
                        rx[2*k+b] = ~rx[2*k+b];     // about 1 in 4
        end
        if (noise == NOISE_ONE)
            rx[rand_bits(5)] ^= 1'b1;
        model_decode(rx, exp_bits, exp_metric);
        if (noise == NOISE_NONE)
            assert (exp_bits == data && exp_metric == 0)
                else report_failure("reference decoder disagrees with a clean block");
        exp_block_q.push_back(exp_bits);
        exp_metric_q.push_back(exp_metric);
        for (int k = 0; k < DEPTH; k++)
        begin
            if (gaps)
                repeat (rand_bits(2))
                begin
                    tick();
                    i_valid = 1'b0;
                end
            tick();
            i_valid = 1'b1;
            i_sym   = rx[2*k +: 2];
            if (k == DEPTH - 1)
                exp_cycle_q.push_back(cyc + LATENCY);
        end
    endtask

    initial
    begin
        lfsr        = 16'd6;
        cyc         = 0;
        blocks_done = 0;
        rst         = 1'b0;
        i_valid     = 1'b0;
        i_sym       = '0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        repeat (8) tick(); // idle cycles where nothing may come out
        run_block(NOISE_NONE, 1'b0);
        run_block(NOISE_NONE, 1'b0);
        run_block(NOISE_NONE, 1'b0);
        run_block(NOISE_NONE, 1'b0);
        repeat (4) run_block(NOISE_ONE, 1'b0);
        repeat (6) run_block(NOISE_DENSE, 1'b0);
        repeat (6) run_block(NOISE_DENSE, 1'b1);
        repeat (4) run_block(NOISE_ONE, 1'b1);
        while (exp_cycle_q.size() > 0)
        begin
            tick();
            i_valid = 1'b0;
        end
        repeat (DEPTH + 4) tick();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
src/viterbi_code_pkg.sv
src/viterbi_path_pkg.sv
src/acs_unit.sv
src/survivor_mem.sv
src/traceback_unit.sv
src/viterbi_top.sv
testbench/tb_viterbi.sv

/* Makefile */
TOP = tb_viterbi

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
